// File: hdl/ros2_ether_pkg.sv
`default_nettype none

package ros2_ether_pkg;

  // IP protocol number of UDP
  localparam logic [7:0] ip_proto_udp = 8'd17;

  // IPv4 header without options
  localparam logic [15:0] ip_hdr_len = 16'd20;

  // Source or destination IP, then payload length
  localparam int prefix_bytes = 6;

  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] pkt_len_t;

  // Byte view for shifting, field view for load and parse.
  // bytes[5] is the most significant address byte.
  typedef union packed {
    logic [prefix_bytes-1:0][7:0] bytes;
    struct packed {
      ip_addr_t addr;
      pkt_len_t len;
    } fields;
  } stream_prefix_u;

  // Owner of the application data buffer
  typedef enum logic [1:0] {
    grant_none = 2'b00,
    grant_ip   = 2'b01,
    grant_cpu  = 2'b10
  } grant_state_t;

endpackage

`default_nettype wire

// File: hdl/byte_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module byte_fifo #(
  parameter int DEPTH = 16
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        i_wr,
  input  wire  [7:0] i_din,
  output logic       o_full,
  input  wire        i_rd,
  output logic [7:0] o_dout,
  output logic       o_empty
);

  localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cw = $clog2(DEPTH + 1);

  logic [7:0]    mem [DEPTH];
  logic [aw-1:0] r_wr_ptr;
  logic [aw-1:0] r_rd_ptr;
  logic [cw-1:0] r_count;
  logic          wr_en;
  logic          rd_en;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
    next_ptr = (ptr == aw'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_full  = (r_count == cw'(DEPTH));
  assign o_empty = (r_count == '0);
  assign wr_en   = i_wr && !o_full;
  assign rd_en   = i_rd && !o_empty;

  // Head word is visible without a read
  assign o_dout = mem[r_rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[r_wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (wr_en) begin
        r_wr_ptr <= next_ptr(r_wr_ptr);
      end
      if (rd_en) begin
        r_rd_ptr <= next_ptr(r_rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/ip_rx_adapter.sv
`default_nettype none
`timescale 1ns/100ps

module ip_rx_adapter (
  input  wire                       clk,
  input  wire                       rst_n,
  input  ros2_ether_pkg::ip_addr_t  i_local_ip,

  input  wire                       i_rx_hdr_valid,
  output logic                      o_rx_hdr_ready,
  input  wire  [7:0]                i_rx_protocol,
  input  ros2_ether_pkg::ip_addr_t  i_rx_source_ip,
  input  ros2_ether_pkg::ip_addr_t  i_rx_dest_ip,
  input  ros2_ether_pkg::pkt_len_t  i_rx_length,

  input  wire                       i_rx_tvalid,
  input  wire  [7:0]                i_rx_tdata,
  input  wire                       i_rx_tlast,
  output logic                      o_rx_tready,

  output logic                      o_wr,
  output logic [7:0]                o_din,
  input  wire                       i_full
);

  import ros2_ether_pkg::*;

  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_prefix  = 2'd1;
  localparam logic [1:0] st_payload = 2'd2;
  localparam logic [1:0] st_drain   = 2'd3;

  localparam int cnt_w = $clog2(prefix_bytes);
  localparam logic [cnt_w-1:0] prefix_last = cnt_w'(prefix_bytes - 1);

  logic [1:0]       r_state;
  logic             r_hdr_ready;
  logic [cnt_w-1:0] r_cnt;
  stream_prefix_u   r_prefix;
  ip_addr_t         local_ip;
  logic             hdr_fire;
  logic             accept;
  logic             prefix_wr;
  logic             payload_wr;

  // Local address arrives least significant byte first
  assign local_ip = {i_local_ip[7:0], i_local_ip[15:8], i_local_ip[23:16], i_local_ip[31:24]};

  assign hdr_fire = r_hdr_ready && i_rx_hdr_valid;
  assign accept   = (i_rx_protocol == ip_proto_udp) && (i_rx_dest_ip == local_ip);

  assign prefix_wr  = (r_state == st_prefix) && !i_full;
  assign payload_wr = (r_state == st_payload) && i_rx_tvalid && !i_full;

  assign o_rx_hdr_ready = r_hdr_ready;
  assign o_rx_tready    = ((r_state == st_payload) && !i_full) || (r_state == st_drain);
  assign o_wr           = prefix_wr || payload_wr;
  assign o_din          = (r_state == st_prefix) ? r_prefix.bytes[prefix_bytes-1] : i_rx_tdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_state     <= st_idle;
      r_hdr_ready <= 1'b0;
      r_cnt       <= '0;
    end else begin
      case (r_state)
        st_idle: begin
          r_cnt <= '0;
          if (hdr_fire) begin
            r_hdr_ready <= 1'b0;
            r_state     <= accept ? st_prefix : st_drain;
          end else begin
            r_hdr_ready <= 1'b1;
          end
        end
        st_prefix: begin
          if (prefix_wr) begin
            r_cnt <= r_cnt + 1'b1;
            if (r_cnt == prefix_last) begin
              r_state <= st_payload;
            end
          end
        end
        st_payload: begin
          if (payload_wr && i_rx_tlast) begin
            r_state <= st_idle;
          end
        end
        st_drain: begin
          // Rejected packet, swallow payload up to tlast
          if (i_rx_tvalid && i_rx_tlast) begin
            r_state <= st_idle;
          end
        end
        default: r_state <= st_idle;
      endcase
    end
  end

  // Load by field, send MSB first by byte
  always_ff @(posedge clk) begin
    if (hdr_fire) begin
      r_prefix.fields.addr <= i_rx_source_ip;
      r_prefix.fields.len  <= i_rx_length - ip_hdr_len;
    end else if (prefix_wr) begin
      r_prefix.bytes <= {r_prefix.bytes[prefix_bytes-2:0], 8'h00};
    end
  end

endmodule

`default_nettype wire

// File: hdl/ip_tx_adapter.sv
`default_nettype none
`timescale 1ns/100ps

module ip_tx_adapter (
  input  wire                       clk,
  input  wire                       rst_n,

  input  wire                       i_empty,
  input  wire  [7:0]                i_dout,
  output logic                      o_rd,

  output logic                      o_tx_hdr_valid,
  input  wire                       i_tx_hdr_ready,
  output ros2_ether_pkg::ip_addr_t  o_tx_dest_ip,
  output ros2_ether_pkg::pkt_len_t  o_tx_length,

  output logic                      o_tx_tvalid,
  output logic [7:0]                o_tx_tdata,
  output logic                      o_tx_tlast,
  input  wire                       i_tx_tready
);

  import ros2_ether_pkg::*;

  localparam logic [1:0] st_collect = 2'd0;
  localparam logic [1:0] st_header  = 2'd1;
  localparam logic [1:0] st_payload = 2'd2;

  localparam int cnt_w = $clog2(prefix_bytes);
  localparam logic [cnt_w-1:0] prefix_last = cnt_w'(prefix_bytes - 1);

  logic [1:0]       r_state;
  logic [cnt_w-1:0] r_cnt;
  pkt_len_t         r_remain;
  stream_prefix_u   r_prefix;
  logic             prefix_rd;
  logic             hdr_fire;
  logic             payload_fire;

  assign prefix_rd    = (r_state == st_collect) && !i_empty;
  assign hdr_fire     = o_tx_hdr_valid && i_tx_hdr_ready;
  assign payload_fire = o_tx_tvalid && i_tx_tready;

  assign o_rd = prefix_rd || payload_fire;

  // Header fields come straight from the field view
  assign o_tx_hdr_valid = (r_state == st_header);
  assign o_tx_dest_ip   = r_prefix.fields.addr;
  assign o_tx_length    = r_prefix.fields.len + ip_hdr_len;

  // Payload is the FIFO head, so it holds while stalled
  assign o_tx_tvalid = (r_state == st_payload) && !i_empty;
  assign o_tx_tdata  = i_dout;
  assign o_tx_tlast  = (r_state == st_payload) && (r_remain == 16'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_state  <= st_collect;
      r_cnt    <= '0;
      r_remain <= '0;
    end else begin
      case (r_state)
        st_collect: begin
          if (prefix_rd) begin
            r_cnt <= r_cnt + 1'b1;
            if (r_cnt == prefix_last) begin
              r_cnt   <= '0;
              r_state <= st_header;
            end
          end
        end
        st_header: begin
          if (hdr_fire) begin
            r_remain <= r_prefix.fields.len;
            // Empty payload goes straight back for the next prefix
            r_state  <= (r_prefix.fields.len == '0) ? st_collect : st_payload;
          end
        end
        st_payload: begin
          if (payload_fire) begin
            r_remain <= r_remain - 1'b1;
            if (r_remain == 16'd1) begin
              r_state <= st_collect;
            end
          end
        end
        default: r_state <= st_collect;
      endcase
    end
  end

  // Bytes enter at the bottom, first byte ends up as address MSB
  always_ff @(posedge clk) begin
    if (prefix_rd) begin
      r_prefix.bytes <= {r_prefix.bytes[prefix_bytes-2:0], i_dout};
    end
  end

endmodule

`default_nettype wire

// File: hdl/buffer_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module buffer_arbiter (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  i_ether_en,

  input  wire  i_app_ip_req,
  input  wire  i_app_ip_rel,
  input  wire  i_app_cpu_req,
  input  wire  i_app_cpu_rel,
  output logic o_app_ip_grant,
  output logic o_app_cpu_grant,

  input  wire  i_udp_rxbuf_ip_rel,
  input  wire  i_udp_rxbuf_cpu_rel,
  output logic o_udp_rxbuf_ip_grant,
  output logic o_udp_rxbuf_cpu_grant
);

  import ros2_ether_pkg::*;

  grant_state_t r_app_grant;
  // High while the CPU owns the UDP receive buffer
  logic         r_udp_cpu_own;

  assign o_app_ip_grant  = i_ether_en && (r_app_grant == grant_ip);
  assign o_app_cpu_grant = i_ether_en && (r_app_grant == grant_cpu);

  assign o_udp_rxbuf_ip_grant  = i_ether_en && !r_udp_cpu_own;
  assign o_udp_rxbuf_cpu_grant = i_ether_en && r_udp_cpu_own;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_app_grant <= grant_none;
    end else begin
      case (r_app_grant)
        grant_none: begin
          // IP side wins a tie
          if (i_app_ip_req) begin
            r_app_grant <= grant_ip;
          end else if (i_app_cpu_req) begin
            r_app_grant <= grant_cpu;
          end
        end
        grant_ip: begin
          if (i_app_ip_rel) begin
            r_app_grant <= grant_none;
          end
        end
        grant_cpu: begin
          if (i_app_cpu_rel) begin
            r_app_grant <= grant_none;
          end
        end
        default: r_app_grant <= grant_none;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_udp_cpu_own <= 1'b0;
    end else if (!r_udp_cpu_own && i_udp_rxbuf_ip_rel) begin
      r_udp_cpu_own <= 1'b1;
    end else if (r_udp_cpu_own && i_udp_rxbuf_cpu_rel) begin
      r_udp_cpu_own <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ros2_ether_bridge.sv
`default_nettype none
`timescale 1ns/100ps

module ros2_ether_bridge #(
  parameter int RX_FIFO_DEPTH = 64,
  parameter int TX_FIFO_DEPTH = 64
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       i_ether_en,
  input  ros2_ether_pkg::ip_addr_t  i_local_ip,

  // IP receive header and payload
  input  wire                       i_rx_hdr_valid,
  output logic                      o_rx_hdr_ready,
  input  wire  [7:0]                i_rx_protocol,
  input  ros2_ether_pkg::ip_addr_t  i_rx_source_ip,
  input  ros2_ether_pkg::ip_addr_t  i_rx_dest_ip,
  input  ros2_ether_pkg::pkt_len_t  i_rx_length,
  input  wire                       i_rx_tvalid,
  input  wire  [7:0]                i_rx_tdata,
  input  wire                       i_rx_tlast,
  output logic                      o_rx_tready,

  // IP transmit header and payload
  output logic                      o_tx_hdr_valid,
  input  wire                       i_tx_hdr_ready,
  output ros2_ether_pkg::ip_addr_t  o_tx_dest_ip,
  output ros2_ether_pkg::pkt_len_t  o_tx_length,
  output logic                      o_tx_tvalid,
  output logic [7:0]                o_tx_tdata,
  output logic                      o_tx_tlast,
  input  wire                       i_tx_tready,

  // Protocol core byte streams
  output logic [7:0]                o_core_rx_byte,
  output logic                      o_core_rx_avail,
  input  wire                       i_core_rx_rd,
  input  wire                       i_core_tx_wr,
  input  wire  [7:0]                i_core_tx_byte,
  output logic                      o_core_tx_ready,

  // Buffer ownership
  input  wire                       i_app_ip_req,
  input  wire                       i_app_ip_rel,
  input  wire                       i_app_cpu_req,
  input  wire                       i_app_cpu_rel,
  output logic                      o_app_ip_grant,
  output logic                      o_app_cpu_grant,
  input  wire                       i_udp_rxbuf_ip_rel,
  input  wire                       i_udp_rxbuf_cpu_rel,
  output logic                      o_udp_rxbuf_ip_grant,
  output logic                      o_udp_rxbuf_cpu_grant
);

  logic       rx_wr;
  logic [7:0] rx_din;
  logic       rx_full;
  logic       rx_empty;
  logic       tx_rd;
  logic [7:0] tx_dout;
  logic       tx_full;
  logic       tx_empty;

  assign o_core_rx_avail = !rx_empty;
  assign o_core_tx_ready = !tx_full;

  ip_rx_adapter ip_rx_adapter_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_local_ip     (i_local_ip),
    .i_rx_hdr_valid (i_rx_hdr_valid),
    .o_rx_hdr_ready (o_rx_hdr_ready),
    .i_rx_protocol  (i_rx_protocol),
    .i_rx_source_ip (i_rx_source_ip),
    .i_rx_dest_ip   (i_rx_dest_ip),
    .i_rx_length    (i_rx_length),
    .i_rx_tvalid    (i_rx_tvalid),
    .i_rx_tdata     (i_rx_tdata),
    .i_rx_tlast     (i_rx_tlast),
    .o_rx_tready    (o_rx_tready),
    .o_wr           (rx_wr),
    .o_din          (rx_din),
    .i_full         (rx_full)
  );

  byte_fifo #(
    .DEPTH (RX_FIFO_DEPTH)
  ) rx_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr    (rx_wr),
    .i_din   (rx_din),
    .o_full  (rx_full),
    .i_rd    (i_core_rx_rd),
    .o_dout  (o_core_rx_byte),
    .o_empty (rx_empty)
  );

  byte_fifo #(
    .DEPTH (TX_FIFO_DEPTH)
  ) tx_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr    (i_core_tx_wr),
    .i_din   (i_core_tx_byte),
    .o_full  (tx_full),
    .i_rd    (tx_rd),
    .o_dout  (tx_dout),
    .o_empty (tx_empty)
  );

  ip_tx_adapter ip_tx_adapter_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_empty        (tx_empty),
    .i_dout         (tx_dout),
    .o_rd           (tx_rd),
    .o_tx_hdr_valid (o_tx_hdr_valid),
    .i_tx_hdr_ready (i_tx_hdr_ready),
    .o_tx_dest_ip   (o_tx_dest_ip),
    .o_tx_length    (o_tx_length),
    .o_tx_tvalid    (o_tx_tvalid),
    .o_tx_tdata     (o_tx_tdata),
    .o_tx_tlast     (o_tx_tlast),
    .i_tx_tready    (i_tx_tready)
  );

  buffer_arbiter buffer_arbiter_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .i_ether_en            (i_ether_en),
    .i_app_ip_req          (i_app_ip_req),
    .i_app_ip_rel          (i_app_ip_rel),
    .i_app_cpu_req         (i_app_cpu_req),
    .i_app_cpu_rel         (i_app_cpu_rel),
    .o_app_ip_grant        (o_app_ip_grant),
    .o_app_cpu_grant       (o_app_cpu_grant),
    .i_udp_rxbuf_ip_rel    (i_udp_rxbuf_ip_rel),
    .i_udp_rxbuf_cpu_rel   (i_udp_rxbuf_cpu_rel),
    .o_udp_rxbuf_ip_grant  (o_udp_rxbuf_ip_grant),
    .o_udp_rxbuf_cpu_grant (o_udp_rxbuf_cpu_grant)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release just after a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/ros2_ether_bridge_asserts.sv
`default_nettype none
`timescale 1ns/100ps

module ros2_ether_bridge_asserts (
  input wire       clk,
  input wire       rst_n,
  input wire       o_tx_hdr_valid,
  input wire       i_tx_hdr_ready,
  input wire       o_tx_tvalid,
  input wire       i_tx_tready,
  input wire [7:0] o_tx_tdata,
  input wire       o_app_ip_grant,
  input wire       o_app_cpu_grant,
  input wire       o_core_rx_avail
);

  hdr_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    o_tx_hdr_valid && !i_tx_hdr_ready |=> o_tx_hdr_valid)
    else $error("tx header valid dropped before ready");

  tdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_tx_tvalid && !i_tx_tready |=> o_tx_tvalid && $stable(o_tx_tdata))
    else $error("tx payload changed while stalled");

  grants_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_app_ip_grant && o_app_cpu_grant))
    else $error("both application buffer grants high");

  avail_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !o_core_rx_avail)
    else $error("receive data available right after reset");

endmodule

bind ros2_ether_bridge ros2_ether_bridge_asserts asserts_i (
  .clk             (clk),
  .rst_n           (rst_n),
  .o_tx_hdr_valid  (o_tx_hdr_valid),
  .i_tx_hdr_ready  (i_tx_hdr_ready),
  .o_tx_tvalid     (o_tx_tvalid),
  .i_tx_tready     (i_tx_tready),
  .o_tx_tdata      (o_tx_tdata),
  .o_app_ip_grant  (o_app_ip_grant),
  .o_app_cpu_grant (o_app_cpu_grant),
  .o_core_rx_avail (o_core_rx_avail)
);

`default_nettype wire

// File: testbench/tb_ros2_ether_bridge.sv
`default_nettype none
`timescale 1ns/100ps

module tb_ros2_ether_bridge;

  localparam int timeout_cycles = 2000;
  localparam logic [31:0] local_ip = 32'hc0a80164;
  localparam logic [31:0] rx_src_ip = 32'hc0a8010a;

  logic clk;
  logic rst_n;
  logic i_ether_en, i_rx_hdr_valid, i_rx_tvalid, i_rx_tlast, i_tx_hdr_ready, i_tx_tready;
  logic i_core_rx_rd, i_core_tx_wr;
  logic i_app_ip_req, i_app_ip_rel, i_app_cpu_req, i_app_cpu_rel;
  logic i_udp_rxbuf_ip_rel, i_udp_rxbuf_cpu_rel;
  logic [31:0] i_local_ip, i_rx_source_ip, i_rx_dest_ip;
  logic [15:0] i_rx_length;
  logic [7:0] i_rx_protocol, i_rx_tdata, i_core_tx_byte;
  logic o_rx_hdr_ready, o_rx_tready, o_tx_hdr_valid, o_tx_tvalid, o_tx_tlast;
  logic o_core_rx_avail, o_core_tx_ready;
  logic o_app_ip_grant, o_app_cpu_grant, o_udp_rxbuf_ip_grant, o_udp_rxbuf_cpu_grant;
  logic [31:0] o_tx_dest_ip;
  logic [15:0] o_tx_length;
  logic [7:0] o_tx_tdata, o_core_rx_byte;

  logic [7:0]  rx_exp[$];
  logic [47:0] tx_hdr_exp[$];
  logic [8:0]  tx_byte_exp[$];
  string group[$];
  string cur_name = "reset";
  int errors = 0;
  int group_errors = 0;
  int tests = 0;
  int failed = 0;
  int seed;

  tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(3)) clock_gen_i (.clk(clk), .rst_n(rst_n));

  ros2_ether_bridge #(.RX_FIFO_DEPTH(16), .TX_FIFO_DEPTH(16)) ros2_ether_bridge_i (.*);

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic timeout_error(input string what);
    $display("Timeout in %s while waiting for %s", cur_name, what);
    errors++;
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    assert (exp === act) else begin
      $display("Mismatch %s %s expected %0d actual %0d", cur_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic send_rx(input logic [31:0] dest, input logic [7:0] proto,
                         input int len, input logic [7:0] first);
    int t;
    i_rx_hdr_valid = 1'b1;
    i_rx_protocol  = proto;
    i_rx_source_ip = rx_src_ip;
    i_rx_dest_ip   = dest;
    i_rx_length    = 16'(len + 20);
    if (proto == 8'd17 && dest == local_ip) begin
      for (int b = 3; b >= 0; b--) rx_exp.push_back(rx_src_ip[8*b +: 8]);
      rx_exp.push_back(8'(len >> 8));
      rx_exp.push_back(8'(len));
      for (int k = 0; k < len; k++) rx_exp.push_back(8'(first + 8'(k)));
    end
    t = 0;
    @(negedge clk);
    while (!o_rx_hdr_ready && t < timeout_cycles) begin
      @(negedge clk);
      t++;
    end
    if (t == timeout_cycles) timeout_error("rx header ready");
    tick();
    i_rx_hdr_valid = 1'b0;
    for (int k = 0; k < len; k++) begin
      i_rx_tvalid = 1'b1;
      i_rx_tdata  = 8'(first + 8'(k));
      i_rx_tlast  = (k == len - 1);
      t = 0;
      @(negedge clk);
      while (!o_rx_tready && t < timeout_cycles) begin
        @(negedge clk);
        t++;
      end
      if (t == timeout_cycles) timeout_error("rx payload ready");
      tick();
    end
    i_rx_tvalid = 1'b0;
    i_rx_tlast  = 1'b0;
  endtask

  task automatic write_core_byte(input logic [7:0] b);
    int t;
    t = 0;
    @(negedge clk);
    while (!o_core_tx_ready && t < timeout_cycles) begin
      @(negedge clk);
      t++;
    end
    if (t == timeout_cycles) timeout_error("tx FIFO space");
    tick();
    i_core_tx_wr   = 1'b1;
    i_core_tx_byte = b;
    tick();
    i_core_tx_wr = 1'b0;
  endtask

  task automatic send_tx(input logic [31:0] dest, input int len, input logic [7:0] first);
    tx_hdr_exp.push_back({dest, 16'(len + 20)});
    for (int k = 0; k < len; k++) tx_byte_exp.push_back({k == len - 1, 8'(first + 8'(k))});
    for (int b = 3; b >= 0; b--) write_core_byte(dest[8*b +: 8]);
    write_core_byte(8'(len >> 8));
    write_core_byte(8'(len));
    for (int k = 0; k < len; k++) write_core_byte(8'(first + 8'(k)));
  endtask

  // Waits for all queued traffic and reports every test of the group
  task automatic finish_group();
    int t;
    t = 0;
    while ((rx_exp.size() + tx_hdr_exp.size() + tx_byte_exp.size()) != 0 &&
           t < timeout_cycles) begin
      tick();
      t++;
    end
    if (t == timeout_cycles) timeout_error("queued packets to drain");
    repeat (10) tick();
    foreach (group[i]) begin
      $display("%s: %s", group[i], (errors == group_errors) ? "pass" : "fail");
      tests++;
      if (errors != group_errors) failed++;
    end
    group.delete();
    group_errors = errors;
  endtask

  task automatic pulse_tick();
    tick();
    {i_app_ip_req, i_app_ip_rel, i_app_cpu_req, i_app_cpu_rel} = 4'b0000;
    {i_udp_rxbuf_ip_rel, i_udp_rxbuf_cpu_rel} = 2'b00;
  endtask

  // Random back-pressure on the core read and the IP transmit side
  initial begin
    logic [31:0] r;
    seed = 32'h1012;
    i_core_rx_rd   = 1'b0;
    i_tx_tready    = 1'b0;
    i_tx_hdr_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      r = $random(seed);
      i_core_rx_rd   = r[0] | r[1];
      i_tx_tready    = r[2] | r[3];
      i_tx_hdr_ready = r[4] | r[5];
    end
  end

  // Output monitor sampling at the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && i_core_rx_rd && o_core_rx_avail) begin
        assert (rx_exp.size() != 0) else begin
          $display("Unexpected receive byte %h in %s", o_core_rx_byte, cur_name);
          errors++;
        end
        if (rx_exp.size() != 0) begin
          assert (o_core_rx_byte === rx_exp[0]) else begin
            $display("Mismatch %s expected %h actual %h", cur_name, rx_exp[0], o_core_rx_byte);
            errors++;
          end
          void'(rx_exp.pop_front());
        end
      end
      if (rst_n && o_tx_hdr_valid && i_tx_hdr_ready) begin
        assert (tx_hdr_exp.size() != 0) else begin
          $display("Unexpected transmit header in %s", cur_name);
          errors++;
        end
        if (tx_hdr_exp.size() != 0) begin
          assert ({o_tx_dest_ip, o_tx_length} === tx_hdr_exp[0]) else begin
            $display("Mismatch %s expected %h actual %h", cur_name, tx_hdr_exp[0],
                     {o_tx_dest_ip, o_tx_length});
            errors++;
          end
          void'(tx_hdr_exp.pop_front());
        end
      end
      if (rst_n && o_tx_tvalid && i_tx_tready) begin
        assert (tx_byte_exp.size() != 0) else begin
          $display("Unexpected transmit payload byte in %s", cur_name);
          errors++;
        end
        if (tx_byte_exp.size() != 0) begin
          assert ({o_tx_tlast, o_tx_tdata} === tx_byte_exp[0]) else begin
            $display("Mismatch %s expected %h actual %h", cur_name, tx_byte_exp[0],
                     {o_tx_tlast, o_tx_tdata});
            errors++;
          end
          void'(tx_byte_exp.pop_front());
        end
      end
    end
  end

  initial begin
    #2_000_000;
    $display("Simulation time limit reached");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int fd, n, t, rc, proto, len, first, wt;
    logic [31:0] addr;
    string line, name, kind;
    i_ether_en = 1'b1;
    i_local_ip = {local_ip[7:0], local_ip[15:8], local_ip[23:16], local_ip[31:24]};
    {i_rx_hdr_valid, i_rx_tvalid, i_rx_tlast, i_core_tx_wr} = 4'b0000;
    {i_app_ip_req, i_app_ip_rel, i_app_cpu_req, i_app_cpu_rel} = 4'b0000;
    {i_udp_rxbuf_ip_rel, i_udp_rxbuf_cpu_rel} = 2'b00;
    i_rx_protocol  = 8'd0;
    i_rx_source_ip = 32'd0;
    i_rx_dest_ip   = 32'd0;
    i_rx_length    = 16'd0;
    i_rx_tdata     = 8'd0;
    i_core_tx_byte = 8'd0;
    // First falling edge after release, before any active clock edge
    t = 0;
    @(negedge clk);
    while (!rst_n && t < 20) begin
      @(negedge clk);
      t++;
    end
    if (!rst_n) begin
      $display("Reset was never released");
      errors++;
    end
    check_bit("rx_hdr_ready", 1'b0, o_rx_hdr_ready);
    check_bit("rx_tready", 1'b0, o_rx_tready);
    check_bit("tx_hdr_valid", 1'b0, o_tx_hdr_valid);
    check_bit("tx_tvalid", 1'b0, o_tx_tvalid);
    check_bit("rx_avail", 1'b0, o_core_rx_avail);
    check_bit("core_tx_ready", 1'b1, o_core_tx_ready);
    check_bit("udp_ip_grant", 1'b1, o_udp_rxbuf_ip_grant);
    check_bit("udp_cpu_grant", 1'b0, o_udp_rxbuf_cpu_grant);
    check_bit("app_ip_grant", 1'b0, o_app_ip_grant);
    check_bit("app_cpu_grant", 1'b0, o_app_cpu_grant);
    tick();
    fd = $fopen("testbench/bridge_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() == 0 || line.getc(0) == 8'h23) continue;
      n = $sscanf(line, "%s %s %h %d %d %h %d", name, kind, addr, proto, len, first, wt);
      if (n != 7) continue;
      cur_name = name;
      group.push_back(name);
      if (kind == "rx") send_rx(addr, 8'(proto), len, 8'(first));
      else send_tx(addr, len, 8'(first));
      if (wt != 0) finish_group();
    end
    if (group.size() != 0) finish_group();

    cur_name = "app_arbiter";
    group.push_back(cur_name);
    {i_app_ip_req, i_app_cpu_req} = 2'b11;
    pulse_tick();
    check_bit("ip_grant", 1'b1, o_app_ip_grant);
    check_bit("cpu_grant", 1'b0, o_app_cpu_grant);
    i_app_ip_rel = 1'b1;
    pulse_tick();
    check_bit("ip_grant", 1'b0, o_app_ip_grant);
    i_app_cpu_req = 1'b1;
    pulse_tick();
    check_bit("cpu_grant", 1'b1, o_app_cpu_grant);
    i_ether_en = 1'b0;
    #1;
    check_bit("cpu_grant_off", 1'b0, o_app_cpu_grant);
    check_bit("udp_ip_grant_off", 1'b0, o_udp_rxbuf_ip_grant);
    i_ether_en = 1'b1;
    i_app_cpu_rel = 1'b1;
    pulse_tick();
    check_bit("cpu_grant", 1'b0, o_app_cpu_grant);
    finish_group();

    cur_name = "udp_rxbuf";
    group.push_back(cur_name);
    i_udp_rxbuf_cpu_rel = 1'b1;
    pulse_tick();
    check_bit("ip_grant", 1'b1, o_udp_rxbuf_ip_grant);
    i_udp_rxbuf_ip_rel = 1'b1;
    pulse_tick();
    check_bit("cpu_grant", 1'b1, o_udp_rxbuf_cpu_grant);
    i_udp_rxbuf_ip_rel = 1'b1;
    pulse_tick();
    check_bit("cpu_grant", 1'b1, o_udp_rxbuf_cpu_grant);
    i_udp_rxbuf_cpu_rel = 1'b1;
    pulse_tick();
    check_bit("ip_grant", 1'b1, o_udp_rxbuf_ip_grant);
    finish_group();

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/bridge_cases.txt
# name kind addr(hex) protocol(dec) payload_len(dec) first_byte(hex) wait_for_drain(0/1)
# payload byte k is first_byte plus k, modulo 256
rx_udp_local rx c0a80164 17 12 10 1
rx_wrong_proto rx c0a80164 6 8 20 1
rx_wrong_ip rx c0a80199 17 8 30 1
rx_after_drop rx c0a80164 17 5 fe 1
tx_basic tx 0a000002 17 10 40 1
tx_long tx 0a000003 17 40 80 1
tx_empty tx 0a000004 17 0 00 1
burst_tx_a tx 0a000005 17 7 f8 0
burst_tx_b tx 0a000006 17 9 01 0
burst_rx_a rx c0a80164 17 20 a0 0
burst_rx_drop rx c0a80164 1 6 55 0
burst_rx_b rx c0a80164 17 3 c0 0
burst_rx_c rx c0a80164 17 30 e0 1
rx_single rx c0a80164 17 1 77 1

// File: filelist.f
hdl/ros2_ether_pkg.sv
hdl/byte_fifo.sv
hdl/ip_rx_adapter.sv
hdl/ip_tx_adapter.sv
hdl/buffer_arbiter.sv
hdl/ros2_ether_bridge.sv
testbench/tb_clock_gen.sv
testbench/ros2_ether_bridge_asserts.sv
testbench/tb_ros2_ether_bridge.sv

// File: run.sh
#!/bin/sh
# Compile and run with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_ros2_ether_bridge -o sim &&
./obj_dir/sim | tee /dev/stderr | grep "TEST OK" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
